//--- cpu_pkg.sv
package cpu_pkg;

  // datapath width shared by every block
  localparam int WORD_W = 16;

  // top nibble of each instruction
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_XOR = 4'd2,
    OP_AND = 4'd3,
    OP_SLL = 4'd4,
    OP_SRA = 4'd5,
    OP_ROR = 4'd6,
    OP_OR  = 4'd7,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_LHB = 4'd11,
    OP_B   = 4'd12,
    OP_BR  = 4'd13,
    OP_PCS = 4'd14,
    OP_HLT = 4'd15
  } opcode_e;

  // branch conditions in instr[11:9]
  // UN is the unconditional case
  typedef enum logic [2:0] {NE, EQ, GT, LT, GE, LE, OV, UN} cond_e;

  // z sits in the top bit so the control register shows Z V N in bits 3..1
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // address bits [17:16] pick the target of an APB access
  typedef enum logic [1:0] {REG_CTRL, REG_IMEM, REG_DMEM, REG_RF} region_e;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [19:0]       paddr;
    logic [WORD_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // debug side of the memories and register file
  // region tells the core which read data to hand back
  typedef struct packed {
    logic              imem_we;
    logic              dmem_we;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic [3:0]        reg_idx;
    region_e           region;
  } dbg_req_t;

endpackage

//--- alu.sv
`timescale 1ns/10ps

module alu
  import cpu_pkg::*;
(
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  input  opcode_e           op,
  output logic [WORD_W-1:0] y,
  output flags_t            flags,
  output flags_t            flag_en
);

  // saturation limits for add and sub
  localparam logic [WORD_W-1:0] SAT_POS = {1'b0, {(WORD_W-1){1'b1}}};
  localparam logic [WORD_W-1:0] SAT_NEG = {1'b1, {(WORD_W-1){1'b0}}};

  logic [WORD_W-1:0]   sum;
  logic [WORD_W-1:0]   diff;
  logic                add_ovf;
  logic                sub_ovf;
  logic [3:0]          shamt;
  logic [2*WORD_W-1:0] ror_wide;

  // shift amount comes in on b, the core feeds instr[3:0] there
  assign shamt = b[3:0];

  assign sum  = a + b;
  assign diff = a - b;

  // overflow when the sign of the result disagrees with the operands
  assign add_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
  assign sub_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

  // rotate by shifting a doubled copy
  assign ror_wide = {a, a} >> shamt;

  always_comb begin
    y       = '0;
    flags.v = 1'b0;
    flag_en = '0;
    case (op)
      OP_ADD: begin
        y       = add_ovf ? (a[WORD_W-1] ? SAT_NEG : SAT_POS) : sum;
        flags.v = add_ovf;
        flag_en = '{z: 1'b1, v: 1'b1, n: 1'b1};
      end
      OP_SUB: begin
        y       = sub_ovf ? (a[WORD_W-1] ? SAT_NEG : SAT_POS) : diff;
        flags.v = sub_ovf;
        flag_en = '{z: 1'b1, v: 1'b1, n: 1'b1};
      end
      OP_XOR: y = a ^ b;
      OP_AND: y = a & b;
      OP_OR:  y = a | b;
      OP_SLL: y = a << shamt;
      OP_SRA: y = $signed(a) >>> shamt;
      OP_ROR: y = ror_wide[WORD_W-1:0];
      default: y = '0;
    endcase
    // logic ops and shifts only touch Z
    if (!op[3] && (op != OP_ADD) && (op != OP_SUB)) begin
      flag_en.z = 1'b1;
    end
    flags.z = (y == '0);
    flags.n = y[WORD_W-1];
  end

endmodule

//--- register_file.sv
`timescale 1ns/10ps

module register_file
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  logic [3:0]        ra1,
  input  logic [3:0]        ra2,
  input  logic [3:0]        wa,
  input  logic [3:0]        dbg_ra,
  input  logic [WORD_W-1:0] wd,
  output logic [WORD_W-1:0] rd1,
  output logic [WORD_W-1:0] rd2,
  output logic [WORD_W-1:0] dbg_rd
);

  logic [WORD_W-1:0] regs [16];

  // writes to r0 are dropped so it keeps its reset value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != 4'd0)) begin
      regs[wa] <= wd;
    end
  end

  // combinational reads, new value shows after the edge
  assign rd1    = regs[ra1];
  assign rd2    = regs[ra2];
  assign dbg_rd = regs[dbg_ra];

  // r0 reads zero in every cycle
  r0_zero_a: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

//--- pc_control.sv
`timescale 1ns/10ps

module pc_control
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              advance,
  input  logic              hold,
  input  opcode_e           op,
  input  cond_e             cond,
  input  logic [8:0]        offset,
  input  logic [WORD_W-1:0] reg_target,
  input  flags_t            flags_in,
  input  flags_t            flag_en,
  output logic [WORD_W-1:0] pc,
  output logic [WORD_W-1:0] pc_plus2,
  output flags_t            flags
);

  logic              taken;
  logic [WORD_W-1:0] branch_target;
  logic [WORD_W-1:0] pc_next;

  assign pc_plus2 = pc + 16'd2;

  // word offset, sign extended and scaled to bytes
  assign branch_target = pc_plus2 + {{(WORD_W-10){offset[8]}}, offset, 1'b0};

  // conditions look at the stored flags only
  always_comb begin
    case (cond)
      NE: taken = !flags.z;
      EQ: taken = flags.z;
      GT: taken = !flags.z && !flags.n;
      LT: taken = flags.n;
      GE: taken = flags.z || !flags.n;
      LE: taken = flags.z || flags.n;
      OV: taken = flags.v;
      UN: taken = 1'b1;
    endcase
  end

  // fetch is word aligned so bit 0 of a register target is dropped
  always_comb begin
    pc_next = pc_plus2;
    if ((op == OP_B) && taken) begin
      pc_next = branch_target;
    end else if ((op == OP_BR) && taken) begin
      pc_next = {reg_target[WORD_W-1:1], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (start) begin
      pc <= '0;
    end else if (advance && !hold) begin
      pc <= pc_next;
    end
  end

  // each flag only moves when the ALU op owns it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (advance) begin
      if (flag_en.z) flags.z <= flags_in.z;
      if (flag_en.v) flags.v <= flags_in.v;
      if (flag_en.n) flags.n <= flags_in.n;
    end
  end

  pc_even_a: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

  // memory and control opcodes must leave the flag register alone
  flag_owner_a: assert property (
    @(posedge clk) disable iff (!rst_n) (advance && (flag_en != '0)) |-> !op[3]
  ) else $error("pc_control: flag update requested for opcode %0d", op);

endmodule

//--- instr_mem.sv
`timescale 1ns/10ps

module instr_mem
  import cpu_pkg::*;
#(
  parameter int IMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic [WORD_W-1:0] addr,
  output logic [WORD_W-1:0] instr,
  input  logic              dbg_we,
  input  logic [WORD_W-1:0] dbg_addr,
  input  logic [WORD_W-1:0] dbg_wdata,
  output logic [WORD_W-1:0] dbg_rdata
);

  localparam int IDX_W = $clog2(IMEM_WORDS);

  logic [WORD_W-1:0] mem [IMEM_WORDS];

  // byte address in, bit 0 ignored
  assign instr     = mem[addr[IDX_W:1]];
  assign dbg_rdata = mem[dbg_addr[IDX_W:1]];

  // only the APB side ever writes program words
  always_ff @(posedge clk) begin
    if (dbg_we) begin
      mem[dbg_addr[IDX_W:1]] <= dbg_wdata;
    end
  end

endmodule

//--- data_mem.sv
`timescale 1ns/10ps

module data_mem
  import cpu_pkg::*;
#(
  parameter int DMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              we,
  input  logic [WORD_W-1:0] addr,
  input  logic [WORD_W-1:0] wdata,
  output logic [WORD_W-1:0] rdata
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [WORD_W-1:0] mem [DMEM_WORDS];

  // single port, the core picks who drives it
  assign rdata = mem[addr[IDX_W:1]];

  // whole words only
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr[IDX_W:1]] <= wdata;
    end
  end

  // a store above the array would alias onto a lower word
  dmem_range_a: assert property (
    @(posedge clk) we |-> (int'(addr[WORD_W-1:1]) < DMEM_WORDS)
  ) else $error("data_mem: write to out of range address %h", addr);

endmodule

//--- cpu.sv
`timescale 1ns/10ps

module cpu
  import cpu_pkg::*;
#(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  input  logic              start,
  input  dbg_req_t          dbg,
  output logic [WORD_W-1:0] dbg_rdata,
  output logic              hlt_seen,
  output logic [WORD_W-1:0] pc,
  output flags_t            flags
);

  logic [WORD_W-1:0] instr;
  opcode_e           op;
  logic              exec;
  logic              is_alu;
  logic              rf_we;
  logic [3:0]        ra1;
  logic [3:0]        ra2;
  logic [WORD_W-1:0] rd1;
  logic [WORD_W-1:0] rd2;
  logic [WORD_W-1:0] wb_data;
  logic [WORD_W-1:0] alu_b;
  logic [WORD_W-1:0] alu_y;
  flags_t            alu_flags;
  flags_t            alu_flag_en;
  logic [WORD_W-1:0] pc_plus2;
  logic [WORD_W-1:0] mem_addr;
  logic [WORD_W-1:0] byte_ins;
  logic              dmem_we;
  logic [WORD_W-1:0] dmem_addr;
  logic [WORD_W-1:0] dmem_wdata;
  logic [WORD_W-1:0] dmem_rdata;
  logic [WORD_W-1:0] imem_dbg_rdata;
  logic [WORD_W-1:0] rf_dbg_rdata;

  assign op     = opcode_e'(instr[15:12]);
  assign is_alu = !instr[15];
  // a restart write wins over the instruction at the old pc
  assign exec     = run && !start;
  assign hlt_seen = run && (op == OP_HLT);

  // byte loads read back their own destination
  assign ra1 = (op == OP_LLB || op == OP_LHB) ? instr[11:8] : instr[7:4];
  // store data register lives in the rd slot
  assign ra2 = (op == OP_SW) ? instr[11:8] : instr[3:0];

  // shifts take the amount straight from the instruction
  assign alu_b = (op inside {OP_SLL, OP_SRA, OP_ROR}) ? {12'd0, instr[3:0]} : rd2;

  // base rounded down to a word, offset counted in words
  assign mem_addr = (rd1 & 16'hFFFE) + {{11{instr[3]}}, instr[3:0], 1'b0};

  assign byte_ins = (op == OP_LHB) ? {instr[7:0], rd1[7:0]} : {rd1[15:8], instr[7:0]};

  always_comb begin
    case (op)
      OP_LW:          wb_data = dmem_rdata;
      OP_LLB, OP_LHB: wb_data = byte_ins;
      OP_PCS:         wb_data = pc_plus2;
      default:        wb_data = alu_y;
    endcase
  end

  assign rf_we = exec && (is_alu || (op inside {OP_LW, OP_LLB, OP_LHB, OP_PCS}));

  // data memory belongs to the core while running and to APB otherwise
  assign dmem_we    = run ? (exec && (op == OP_SW)) : dbg.dmem_we;
  assign dmem_addr  = run ? mem_addr : dbg.addr;
  assign dmem_wdata = run ? rd2 : dbg.wdata;

  // debug read data back to the port
  always_comb begin
    case (dbg.region)
      REG_IMEM: dbg_rdata = imem_dbg_rdata;
      REG_DMEM: dbg_rdata = dmem_rdata;
      REG_RF:   dbg_rdata = rf_dbg_rdata;
      default:  dbg_rdata = '0;
    endcase
  end

  instr_mem #(.IMEM_WORDS(IMEM_WORDS)) imem_i (
    .clk(clk), .addr(pc), .instr(instr),
    .dbg_we(dbg.imem_we), .dbg_addr(dbg.addr), .dbg_wdata(dbg.wdata),
    .dbg_rdata(imem_dbg_rdata)
  );

  data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem_i (
    .clk(clk), .we(dmem_we), .addr(dmem_addr), .wdata(dmem_wdata), .rdata(dmem_rdata)
  );

  register_file rf_i (
    .clk(clk), .rst_n(rst_n), .we(rf_we), .ra1(ra1), .ra2(ra2), .wa(instr[11:8]),
    .dbg_ra(dbg.reg_idx), .wd(wb_data), .rd1(rd1), .rd2(rd2), .dbg_rd(rf_dbg_rdata)
  );

  alu alu_i (
    .a(rd1), .b(alu_b), .op(op), .y(alu_y), .flags(alu_flags), .flag_en(alu_flag_en)
  );

  // HLT freezes the pc until the port drops run
  pc_control pc_ctrl_i (
    .clk(clk), .rst_n(rst_n), .start(start), .advance(exec), .hold(op == OP_HLT),
    .op(op), .cond(cond_e'(instr[11:9])), .offset(instr[8:0]), .reg_target(rd1),
    .flags_in(alu_flags), .flag_en(alu_flag_en), .pc(pc), .pc_plus2(pc_plus2),
    .flags(flags)
  );

endmodule

//--- apb_debug_port.sv
`timescale 1ns/10ps

module apb_debug_port
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  apb_req_t          apb_req,
  output apb_rsp_t          apb_rsp,
  input  logic              hlt_seen,
  input  flags_t            flags,
  output dbg_req_t          dbg,
  input  logic [WORD_W-1:0] dbg_rdata,
  output logic              run,
  output logic              start
);

  region_e region;
  logic    access;
  logic    err;
  logic    wr_ok;
  logic    ctrl_wr;

  assign region = region_e'(apb_req.paddr[17:16]);
  assign access = apb_req.psel && apb_req.penable;

  // memories and registers are locked while the core runs
  // the register file has no write path from outside
  assign err = access && (((region != REG_CTRL) && run) ||
                          ((region == REG_RF) && apb_req.pwrite));

  // writes land on the edge that closes the access phase
  assign wr_ok   = access && apb_req.pwrite && !err;
  assign ctrl_wr = wr_ok && (region == REG_CTRL);

  // start goes out in the same cycle so pc and run change together
  assign start = ctrl_wr && apb_req.pwdata[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else if (ctrl_wr) begin
      run <= apb_req.pwdata[0];
    end else if (hlt_seen) begin
      run <= 1'b0;
    end
  end

  always_comb begin
    dbg.imem_we = wr_ok && (region == REG_IMEM);
    dbg.dmem_we = wr_ok && (region == REG_DMEM);
    dbg.addr    = apb_req.paddr[15:0];
    dbg.wdata   = apb_req.pwdata;
    dbg.reg_idx = apb_req.paddr[3:0];
    dbg.region  = region;
  end

  // no wait states, every access phase completes
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = err;
  assign apb_rsp.prdata  = err ? '0 :
                           (region == REG_CTRL) ? {{(WORD_W-4){1'b0}}, flags, run} :
                           dbg_rdata;

  penable_psel_a: assert property (
    @(posedge clk) disable iff (!rst_n) apb_req.penable |-> apb_req.psel
  );

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_req_t          apb_req,
  output apb_rsp_t          apb_rsp,
  output logic              hlt,
  output logic [WORD_W-1:0] pc
);

  dbg_req_t          dbg;
  logic [WORD_W-1:0] dbg_rdata;
  logic              hlt_seen;
  flags_t            flags;
  logic              run;
  logic              start;

  // hlt follows the core directly, high while HLT sits at pc
  assign hlt = hlt_seen;

  apb_debug_port apb_i (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .hlt_seen(hlt_seen), .flags(flags), .dbg(dbg), .dbg_rdata(dbg_rdata),
    .run(run), .start(start)
  );

  cpu #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) cpu_i (
    .clk(clk), .rst_n(rst_n), .run(run), .start(start), .dbg(dbg),
    .dbg_rdata(dbg_rdata), .hlt_seen(hlt_seen), .pc(pc), .flags(flags)
  );

endmodule

//--- tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu
  import cpu_pkg::*;
();

  // ten programs plus memory fills and readbacks come to about 7000 cycles
  localparam int CYCLE_LIMIT = 20000;

  logic              clk;
  logic              rst_n;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  logic              hlt;
  logic [WORD_W-1:0] pc;

  // reference copy of the architectural state
  logic [15:0] model_regs [16];
  logic [15:0] model_imem [256];
  logic [15:0] model_dmem [256];
  logic [15:0] model_pc;
  flags_t      model_flags;

  // program under construction, HLT is always the last word
  logic [15:0] prog [64];
  int          prog_len;
  int          cycles = 0;

  cpu_top #(.IMEM_WORDS(256), .DMEM_WORDS(256)) dut_i (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp), .hlt(hlt), .pc(pc)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic fail_now(input string why);
    $display("CHECKS FAILED");
    $fatal(1, "%s", why);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_now("timeout, the run went past its cycle limit");
    end
  end

  task automatic check_eq(input string name, input logic [15:0] actual,
                          input logic [15:0] expected);
    assert (actual === expected) else begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      fail_now("value mismatch");
    end
  endtask

  // top two address bits pick the region
  function automatic logic [19:0] region_addr(input region_e r, input logic [15:0] off);
    return {2'b00, r, off};
  endfunction

  // setup and access phase, then one idle cycle
  task automatic apb_xfer(input logic wr, input logic [19:0] addr, input logic [15:0] wdata,
                          output logic [15:0] rdata, output logic slverr);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // response is settled well before the closing edge
    #1;
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    // no wait states, the access phase must complete at once
    check_eq("pready", {15'd0, apb_rsp.pready}, 16'd1);
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  // one instruction by the ISA rules, pc and state move together
  task automatic execute_one(output bit halted);
    logic [15:0] ins;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] next_pc;
    logic [3:0]  rd;
    opcode_e     op;
    int          sa;
    int          sb;
    int          sum;
    bit          wr;
    bit          take;
    bit          eq;
    bit          lt;
    bit          gt;
    ins     = model_imem[model_pc[8:1]];
    op      = opcode_e'(ins[15:12]);
    rd      = ins[11:8];
    a       = model_regs[ins[7:4]];
    b       = model_regs[ins[3:0]];
    addr    = (a & 16'hFFFE) + {{11{ins[3]}}, ins[3:0], 1'b0};
    next_pc = model_pc + 16'd2;
    halted  = 1'b0;
    // most opcodes write rd, the rest clear this below
    wr      = 1'b1;
    res     = 16'd0;
    // branch conditions read the flags from before this instruction
    eq = model_flags.z;
    lt = model_flags.n;
    gt = !eq && !lt;
    case (cond_e'(ins[11:9]))
      NE:      take = !eq;
      EQ:      take = eq;
      GT:      take = gt;
      LT:      take = lt;
      GE:      take = gt || eq;
      LE:      take = lt || eq;
      OV:      take = model_flags.v;
      default: take = 1'b1;
    endcase
    case (op)
      OP_ADD, OP_SUB: begin
        sa  = {{16{a[15]}}, a};
        sb  = {{16{b[15]}}, b};
        sum = (op == OP_ADD) ? sa + sb : sa - sb;
        // clamp to the signed range
        model_flags.v = (sum > 32767) || (sum < -32768);
        if (sum > 32767) res = 16'h7FFF;
        else if (sum < -32768) res = 16'h8000;
        else res = sum[15:0];
        model_flags.n = res[15];
      end
      OP_XOR: res = a ^ b;
      OP_AND: res = a & b;
      OP_OR:  res = a | b;
      OP_SLL: res = a << ins[3:0];
      OP_SRA: res = $signed(a) >>> ins[3:0];
      OP_ROR: begin
        // rotate one bit at a time
        res = a;
        for (int k = 0; k < int'(ins[3:0]); k++) res = {res[0], res[15:1]};
      end
      OP_LW:  res = model_dmem[addr[8:1]];
      OP_SW: begin
        model_dmem[addr[8:1]] = model_regs[rd];
        wr = 1'b0;
      end
      OP_LLB: res = {model_regs[rd][15:8], ins[7:0]};
      OP_LHB: res = {ins[7:0], model_regs[rd][7:0]};
      OP_B: begin
        if (take) next_pc = model_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
        wr = 1'b0;
      end
      OP_BR: begin
        if (take) next_pc = a & 16'hFFFE;
        wr = 1'b0;
      end
      OP_PCS: res = model_pc + 16'd2;
      default: begin
        halted  = 1'b1;
        next_pc = model_pc;
        wr      = 1'b0;
      end
    endcase
    // Z follows every ALU op
    if (!ins[15]) model_flags.z = (res == 16'd0);
    if (wr && rd != 4'd0) model_regs[rd] = res;
    model_pc = next_pc;
  endtask

  function automatic logic [15:0] rand_alu();
    return {4'($urandom % 8), 4'($urandom), 4'($urandom), 4'($urandom)};
  endfunction

  function automatic logic [15:0] rand_misc();
    int pick;
    pick = int'($urandom % 3);
    if (pick == 0) return {OP_PCS, 4'($urandom), 8'd0};
    return {(pick == 1) ? OP_LLB : OP_LHB, 4'($urandom), 8'($urandom)};
  endfunction

  // kind 0 straight line, kind 1 adds loads and stores, kind 2 adds forward branches
  task automatic gen_program(input int kind);
    int          i;
    int          roll;
    logic [15:0] base;
    logic [3:0]  rb;
    prog_len = 40 + int'($urandom % 25);
    i = 0;
    while (i < prog_len - 1) begin
      roll = int'($urandom % 10);
      if (kind == 1 && roll < 4 && i + 3 <= prog_len - 1) begin
        // base leaves room for the signed word offset inside 512 bytes
        base      = 16'd16 + 16'(($urandom % 240) * 2);
        rb        = 4'(1 + $urandom % 15);
        prog[i]   = {OP_LLB, rb, base[7:0]};
        prog[i+1] = {OP_LHB, rb, base[15:8]};
        prog[i+2] = {(roll < 2) ? OP_LW : OP_SW, 4'($urandom), rb, 4'($urandom)};
        i += 3;
      end else if (kind == 2 && roll < 3) begin
        // target lands at most on the HLT
        prog[i] = {OP_B, 3'($urandom), 9'($urandom % (prog_len - 1 - i))};
        i++;
      end else begin
        prog[i] = (roll < 7) ? rand_alu() : rand_misc();
        i++;
      end
    end
    prog[prog_len - 1] = {OP_HLT, 12'd0};
  endtask

  task automatic load_program();
    logic [15:0] rdata;
    logic        err;
    for (int i = 0; i < prog_len; i++) begin
      model_imem[i] = prog[i];
      apb_xfer(1'b1, region_addr(REG_IMEM, 16'(i * 2)), prog[i], rdata, err);
      check_eq("pslverr", {15'd0, err}, 16'd0);
    end
  endtask

  task automatic fill_dmem();
    logic [15:0] rdata;
    logic        err;
    for (int w = 0; w < 256; w++) begin
      model_dmem[w] = 16'($urandom);
      apb_xfer(1'b1, region_addr(REG_DMEM, 16'(w * 2)), model_dmem[w], rdata, err);
      check_eq("pslverr", {15'd0, err}, 16'd0);
    end
  endtask

  task automatic compare_dmem();
    logic [15:0] rdata;
    logic        err;
    for (int w = 0; w < 256; w++) begin
      apb_xfer(1'b0, region_addr(REG_DMEM, 16'(w * 2)), 16'd0, rdata, err);
      check_eq("pslverr", {15'd0, err}, 16'd0);
      check_eq($sformatf("dmem[%0d]", w), rdata, model_dmem[w]);
    end
  endtask

  // all registers, then flags and run from the control register
  task automatic compare_state();
    logic [15:0] rdata;
    logic        err;
    for (int r = 0; r < 16; r++) begin
      apb_xfer(1'b0, region_addr(REG_RF, 16'(r)), 16'd0, rdata, err);
      check_eq("pslverr", {15'd0, err}, 16'd0);
      check_eq($sformatf("r%0d", r), rdata, model_regs[r]);
    end
    apb_xfer(1'b0, region_addr(REG_CTRL, 16'd0), 16'd0, rdata, err);
    check_eq("ctrl", rdata, {12'd0, model_flags.z, model_flags.v, model_flags.n, 1'b0});
  endtask

  // start, then follow pc and hlt on every cycle until the core stops
  task automatic run_checked();
    logic [15:0] rdata;
    logic        err;
    logic        exp_hlt;
    bit          halted;
    int          steps;
    model_pc = 16'd0;
    apb_xfer(1'b1, region_addr(REG_CTRL, 16'd0), 16'd1, rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd0);
    halted = 1'b0;
    steps  = 0;
    while (!halted) begin
      exp_hlt = (model_imem[model_pc[8:1]][15:12] == OP_HLT);
      check_eq("pc", pc, model_pc);
      check_eq("hlt", {15'd0, hlt}, {15'd0, exp_hlt});
      execute_one(halted);
      steps++;
      if (steps > 64) fail_now("program ran past its HLT");
      @(negedge clk);
    end
    // run dropped on the HLT edge, pc stays on the HLT
    check_eq("hlt", {15'd0, hlt}, 16'd0);
    check_eq("pc", pc, model_pc);
  endtask

  task automatic one_program(input int kind);
    gen_program(kind);
    load_program();
    run_checked();
    compare_state();
  endtask

  // BR over three instructions that must stay unexecuted
  task automatic br_directed();
    prog[0] = {OP_LLB, 4'd6, 8'h11};
    prog[1] = {OP_LLB, 4'd5, 8'h0E};
    prog[2] = {OP_LHB, 4'd5, 8'h00};
    prog[3] = {OP_BR, UN, 1'b0, 4'd5, 4'd0};
    prog[4] = {OP_LLB, 4'd6, 8'hEE};
    prog[5] = {OP_LLB, 4'd7, 8'hEE};
    prog[6] = {OP_PCS, 4'd8, 8'h00};
    prog[7] = {OP_LLB, 4'd9, 8'h5A};
    prog[8] = {OP_HLT, 12'd0};
    prog_len = 9;
    load_program();
    run_checked();
    compare_state();
  endtask

  task automatic illegal_access();
    logic [15:0] rdata;
    logic        err;
    logic [15:0] waddr;
    bit          halted;
    int          polls;
    gen_program(0);
    load_program();
    // the model finishes first, the hardware catches up
    model_pc = 16'd0;
    halted   = 1'b0;
    while (!halted) execute_one(halted);
    waddr = 16'(($urandom % 256) * 2);
    apb_xfer(1'b1, region_addr(REG_CTRL, 16'd0), 16'd1, rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd0);
    // program is at least 40 cycles long so these all land mid run
    apb_xfer(1'b1, region_addr(REG_DMEM, waddr), ~model_dmem[waddr[8:1]], rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd1);
    apb_xfer(1'b0, region_addr(REG_DMEM, waddr), 16'd0, rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd1);
    apb_xfer(1'b1, region_addr(REG_IMEM, 16'd0), 16'hFFFF, rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd1);
    apb_xfer(1'b0, region_addr(REG_RF, 16'd1), 16'd0, rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd1);
    polls = 0;
    rdata = 16'd1;
    while (rdata[0]) begin
      apb_xfer(1'b0, region_addr(REG_CTRL, 16'd0), 16'd0, rdata, err);
      polls++;
      if (polls > 64) fail_now("run bit never cleared after the program halted");
    end
    // register file has no outside write path even when idle
    apb_xfer(1'b1, region_addr(REG_RF, 16'd3), ~model_regs[3], rdata, err);
    check_eq("pslverr", {15'd0, err}, 16'd1);
    compare_state();
    apb_xfer(1'b0, region_addr(REG_DMEM, waddr), 16'd0, rdata, err);
    check_eq("dmem_word", rdata, model_dmem[waddr[8:1]]);
    apb_xfer(1'b0, region_addr(REG_IMEM, 16'd0), 16'd0, rdata, err);
    check_eq("imem_word", rdata, model_imem[0]);
  endtask

  initial begin
    void'($urandom(32'h8e8d));
    rst_n   = 1'b0;
    apb_req = '0;
    model_pc    = 16'd0;
    model_flags = '0;
    for (int r = 0; r < 16; r++) model_regs[r] = 16'd0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // reset values
    check_eq("hlt", {15'd0, hlt}, 16'd0);
    check_eq("pc", pc, 16'd0);
    check_eq("pslverr", {15'd0, apb_rsp.pslverr}, 16'd0);
    compare_state();
    for (int p = 0; p < 4; p++) one_program(0);
    fill_dmem();
    for (int p = 0; p < 3; p++) begin
      one_program(1);
      compare_dmem();
    end
    for (int p = 0; p < 3; p++) one_program(2);
    br_directed();
    illegal_access();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- filelist.f
cpu_pkg.sv
alu.sv
register_file.sv
pc_control.sv
instr_mem.sv
data_mem.sv
cpu.sv
apb_debug_port.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module cpu_top
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# the binary exits nonzero on $$fatal, so make fails with it
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir
